/* logic/dcache_geom_pkg.sv */
package dcache_geom_pkg;

  localparam int ways_n   = 4;
  localparam int sets_n   = 16;
  localparam int words_n  = 16;

  // Address split: tag | index | word offset | byte
  localparam int tag_w    = 22;
  localparam int index_w  = 4;
  localparam int offset_w = 4;

  typedef logic [1:0]          way_t;
  typedef logic [index_w-1:0]  index_t;
  typedef logic [offset_w-1:0] offset_t;
  typedef logic [tag_w-1:0]    tag_t;
  typedef logic [1:0]          age_t;

  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  typedef logic [words_n-1:0][31:0] line_t; // Word 0 in the low bits

endpackage

/* logic/dcache_bus_pkg.sv */
package dcache_bus_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0]  byte_en_t;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,    // Array read in flight
    st_compare,
    st_writeback,
    st_refill,
    st_respond
  } ctrl_state_t;

endpackage

/* logic/set_ram.sv */
module set_ram
  import dcache_geom_pkg::*;
  #(
    parameter type entry_t      = logic [31:0],
    parameter int  depth        = sets_n,
    parameter bit  clear_on_rst = 1'b0
  )
  (
    input  logic   clk,
    input  logic   rst,
    input  index_t rd_index,
    output entry_t rd_entry,
    input  logic   wr_en,
    input  index_t wr_index,
    input  entry_t wr_entry
  );

  entry_t mem [depth];

  if (clear_on_rst)
  begin : g_clear
    always_ff @(posedge clk or posedge rst)
      if (rst)
      begin
        for (int i = 0; i < depth; i++)
          mem[i] <= '0; // Drops valid and dirty
      end
      else if (wr_en)
        mem[wr_index] <= wr_entry;
  end
  else
  begin : g_plain
    always_ff @(posedge clk)
      if (wr_en)
        mem[wr_index] <= wr_entry;
  end

  always_ff @(posedge clk)
    rd_entry <= mem[rd_index]; // Old contents on same-edge write

endmodule

/* logic/lru_tracker.sv */
module lru_tracker
  import dcache_geom_pkg::*;
  (
    input  logic              clk,
    input  logic              rst,
    input  index_t            index,
    input  logic [ways_n-1:0] valid,
    input  logic              touch,
    input  way_t              touch_way,
    output way_t              victim
  );

  age_t ages [sets_n][ways_n];

  //////////////////////////////////////////////////
  // Victim choice

  always_comb
  begin
    victim = '0;
    for (int w = 1; w < ways_n; w++)
      if (ages[index][w] > ages[index][victim]) // Strict, lower way keeps ties
        victim = way_t'(w);
    // An invalid way always wins, lowest first
    for (int w = ways_n - 1; w >= 0; w--)
      if (!valid[w])
        victim = way_t'(w);
  end

  //////////////////////////////////////////////////
  // Age update

  always_ff @(posedge clk or posedge rst)
    if (rst)
    begin
      for (int s = 0; s < sets_n; s++)
        for (int w = 0; w < ways_n; w++)
          ages[s][w] <= '0;
    end
    else if (touch)
    begin
      for (int w = 0; w < ways_n; w++)
        if (way_t'(w) == touch_way)
          ages[index][w] <= '0;
        else if (ages[index][w] <= ages[index][touch_way])
          ages[index][w] <= ages[index][w] + 1'b1;
    end

endmodule

/* logic/way_lookup.sv */
module way_lookup
  import dcache_geom_pkg::*;
  (
    input  tag_t                    tag,
    input  tag_entry_t [ways_n-1:0] entries,
    output logic                    hit,
    output way_t                    hit_way,
    output logic [ways_n-1:0]       valid
  );

  logic [ways_n-1:0] match;

  for (genvar w = 0; w < ways_n; w++)
  begin : g_way
    assign valid[w] = entries[w].valid;
    assign match[w] = entries[w].valid && (entries[w].tag == tag);
  end

  assign hit = |match;

  // At most one way matches, lowest index taken anyway
  always_comb
  begin
    hit_way = '0;
    for (int w = ways_n - 1; w >= 0; w--)
      if (match[w])
        hit_way = way_t'(w);
  end

endmodule

/* logic/line_mover.sv */
module line_mover
  import dcache_geom_pkg::*;
  import dcache_bus_pkg::*;
  (
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  logic  write_back,
    input  addr_t line_addr,
    input  line_t wb_line,
    output line_t fill_line,
    output logic  done,
    output logic  rd_req,
    output addr_t rd_addr,
    input  logic  rd_valid,
    input  word_t rd_data,
    output logic  wr_req,
    output addr_t wr_addr,
    output word_t wr_data,
    input  logic  wr_ready
  );

  offset_t cnt;    // Word position in the burst
  addr_t   base;
  line_t   wb_buf;
  logic    beat;
  logic    last;

  assign beat = (rd_req && rd_valid) || (wr_req && wr_ready);
  assign last = beat && (cnt == offset_t'(words_n - 1));

  always_ff @(posedge clk or posedge rst)
    if (rst)
    begin
      rd_req <= 1'b0;
      wr_req <= 1'b0;
      cnt    <= '0;
      done   <= 1'b0;
    end
    else
    begin
      done <= last;
      if (start)
      begin
        cnt    <= '0;
        rd_req <= !write_back;
        wr_req <= write_back;
      end
      else if (beat)
      begin
        cnt <= cnt + 1'b1;
        if (last)
        begin
          rd_req <= 1'b0;
          wr_req <= 1'b0;
        end
      end
    end

  //////////////////////////////////////////////////
  // Burst payload

  always_ff @(posedge clk)
  begin
    if (start)
      base <= line_addr;
    if (start && write_back)
      wb_buf <= wb_line; // Victim snapshot
    if (rd_req && rd_valid)
      fill_line[cnt] <= rd_data;
  end

  assign rd_addr = base;
  assign wr_addr = base;
  assign wr_data = wb_buf[cnt];

endmodule

/* logic/dcache_ctrl.sv */
module dcache_ctrl
  import dcache_geom_pkg::*;
  import dcache_bus_pkg::*;
  (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  logic                    we,
    input  addr_t                   addr,
    input  word_t                   wdata,
    input  byte_en_t                byte_en,
    output word_t                   rdata,
    output logic                    ok,
    input  tag_entry_t [ways_n-1:0] entries,
    input  line_t [ways_n-1:0]      lines,
    input  logic                    hit,
    input  way_t                    hit_way,
    input  way_t                    victim,
    output logic [ways_n-1:0]       tag_we,
    output tag_entry_t              tag_wr_entry,
    output logic [ways_n-1:0]       data_we,
    output line_t                   data_wr_line,
    output index_t                  index,
    output logic                    touch,
    output way_t                    touch_way,
    output logic                    mv_start,
    output logic                    mv_write_back,
    output addr_t                   mv_line_addr,
    output line_t                   mv_wb_line,
    input  line_t                   fill_line,
    input  logic                    mv_done
  );

  ctrl_state_t state;
  ctrl_state_t next_state;
  way_t        vic_q;  // Way being replaced
  tag_t        req_tag;
  offset_t     offset;
  logic        vic_dirty;

  assign req_tag   = addr[31 -: tag_w];
  assign index     = addr[offset_w + 2 +: index_w];
  assign offset    = addr[2 +: offset_w];
  assign vic_dirty = entries[victim].valid && entries[victim].dirty;

  function automatic line_t store_merge(line_t old, offset_t pos, word_t data, byte_en_t be);
    line_t l;
    l = old;
    for (int b = 0; b < 4; b++)
      if (be[b])
        l[pos][8*b +: 8] = data[8*b +: 8];
    return l;
  endfunction

  //////////////////////////////////////////////////
  // Request FSM

  always_ff @(posedge clk or posedge rst)
    if (rst)
    begin
      state <= st_idle;
      vic_q <= '0;
    end
    else
    begin
      state <= next_state;
      if (state == st_compare)
        vic_q <= victim;
    end

  always_comb
  begin
    next_state = state;
    case (state)
      st_idle:      if (req) next_state = st_lookup;
      st_lookup:    next_state = st_compare;
      st_compare:
        if (hit)
          next_state = st_idle;
        else if (vic_dirty)
          next_state = st_writeback;
        else
          next_state = st_refill;
      st_writeback: if (mv_done) next_state = st_refill;
      st_refill:    if (mv_done) next_state = st_respond;
      st_respond:   next_state = st_idle;
      default:      next_state = st_idle;
    endcase
  end

  assign ok        = (state == st_compare && hit) || state == st_respond;
  assign rdata     = (state == st_respond) ? fill_line[offset] : lines[hit_way][offset];
  assign touch     = ok;
  assign touch_way = (state == st_respond) ? vic_q : hit_way;

  // Refill start follows the write-back done
  assign mv_start      = (state == st_compare && !hit) || (state == st_writeback && mv_done);
  assign mv_write_back = state == st_compare && vic_dirty;
  assign mv_line_addr  = mv_write_back ? {entries[victim].tag, index, {(offset_w + 2){1'b0}}}
                                       : {req_tag, index, {(offset_w + 2){1'b0}}};
  assign mv_wb_line    = lines[victim];

  //////////////////////////////////////////////////
  // Array writes

  assign tag_wr_entry = '{valid: 1'b1, dirty: we, tag: req_tag};

  always_comb
  begin
    tag_we       = '0;
    data_we      = '0;
    data_wr_line = fill_line;
    if (state == st_compare && hit && we)
    begin
      tag_we[hit_way]  = 1'b1; // Marks line dirty
      data_we[hit_way] = 1'b1;
      data_wr_line     = store_merge(lines[hit_way], offset, wdata, byte_en);
    end
    else if (state == st_respond)
    begin
      tag_we[vic_q]  = 1'b1;
      data_we[vic_q] = 1'b1;
      if (we)
        data_wr_line = store_merge(fill_line, offset, wdata, byte_en);
    end
  end

endmodule

/* logic/dcache_top.sv */
module dcache_top
  import dcache_geom_pkg::*;
  import dcache_bus_pkg::*;
  (
    input  logic     clk,
    input  logic     rst,
    input  logic     req,
    input  logic     we,
    input  addr_t    addr,
    input  word_t    wdata,
    input  byte_en_t byte_en,
    output word_t    rdata,
    output logic     ok,
    output logic     rd_req,
    output addr_t    rd_addr,
    input  logic     rd_valid,
    input  word_t    rd_data,
    output logic     wr_req,
    output addr_t    wr_addr,
    output word_t    wr_data,
    input  logic     wr_ready
  );

  tag_entry_t [ways_n-1:0] entries;
  line_t [ways_n-1:0]      lines;
  logic [ways_n-1:0]       tag_we;
  logic [ways_n-1:0]       data_we;
  logic [ways_n-1:0]       valid;
  tag_entry_t              tag_wr_entry;
  line_t                   data_wr_line;
  line_t                   mv_wb_line;
  line_t                   fill_line;
  index_t                  index;
  logic                    hit;
  logic                    touch;
  logic                    mv_start;
  logic                    mv_write_back;
  logic                    mv_done;
  way_t                    hit_way;
  way_t                    victim;
  way_t                    touch_way;
  addr_t                   mv_line_addr;

  //////////////////////////////////////////////////
  // Tag and data arrays, one pair per way

  for (genvar w = 0; w < ways_n; w++)
  begin : g_way
    set_ram #(.entry_t(tag_entry_t), .depth(sets_n), .clear_on_rst(1'b1)) i_tag_ram (
      .clk(clk), .rst(rst), .rd_index(index), .rd_entry(entries[w]),
      .wr_en(tag_we[w]), .wr_index(index), .wr_entry(tag_wr_entry));

    set_ram #(.entry_t(line_t), .depth(sets_n), .clear_on_rst(1'b0)) i_data_ram (
      .clk(clk), .rst(rst), .rd_index(index), .rd_entry(lines[w]),
      .wr_en(data_we[w]), .wr_index(index), .wr_entry(data_wr_line));
  end

  dcache_ctrl i_dcache_ctrl (
    .clk(clk), .rst(rst), .req(req), .we(we), .addr(addr), .wdata(wdata),
    .byte_en(byte_en), .rdata(rdata), .ok(ok), .entries(entries), .lines(lines),
    .hit(hit), .hit_way(hit_way), .victim(victim), .tag_we(tag_we),
    .tag_wr_entry(tag_wr_entry), .data_we(data_we), .data_wr_line(data_wr_line),
    .index(index), .touch(touch), .touch_way(touch_way), .mv_start(mv_start),
    .mv_write_back(mv_write_back), .mv_line_addr(mv_line_addr),
    .mv_wb_line(mv_wb_line), .fill_line(fill_line), .mv_done(mv_done));

  way_lookup i_way_lookup (
    .tag(addr[31 -: tag_w]), .entries(entries), .hit(hit), .hit_way(hit_way),
    .valid(valid));

  lru_tracker i_lru_tracker (
    .clk(clk), .rst(rst), .index(index), .valid(valid), .touch(touch),
    .touch_way(touch_way), .victim(victim));

  line_mover i_line_mover (
    .clk(clk), .rst(rst), .start(mv_start), .write_back(mv_write_back),
    .line_addr(mv_line_addr), .wb_line(mv_wb_line), .fill_line(fill_line),
    .done(mv_done), .rd_req(rd_req), .rd_addr(rd_addr), .rd_valid(rd_valid),
    .rd_data(rd_data), .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
    .wr_ready(wr_ready));

endmodule

/* verification/dcache_properties.sv */
module dcache_properties
  import dcache_bus_pkg::*;
  (
    input logic  clk,
    input logic  rst,
    input logic  ok,
    input logic  rd_req,
    input logic  wr_req,
    input addr_t rd_addr,
    input addr_t wr_addr
  );

  ok_single_cycle: assert property (@(posedge clk) disable iff (rst) ok |=> !ok)
    else $error("ok held high for more than one cycle");

  // Memory bursts never overlap
  bursts_exclusive: assert property (@(posedge clk) disable iff (rst) !(rd_req && wr_req))
    else $error("rd_req and wr_req high together");

  rd_addr_stable: assert property (@(posedge clk) disable iff (rst)
    rd_req |=> (!rd_req || $stable(rd_addr)))
    else $error("rd_addr changed during a read burst");

  wr_addr_stable: assert property (@(posedge clk) disable iff (rst)
    wr_req |=> (!wr_req || $stable(wr_addr)))
    else $error("wr_addr changed during a write burst");

endmodule

/* verification/dcache_tb.sv */
module dcache_tb
  import dcache_bus_pkg::*;
  ();

  logic     clk;
  logic     rst;
  logic     req;
  logic     we;
  addr_t    addr;
  word_t    wdata;
  byte_en_t byte_en;
  word_t    rdata;
  logic     ok;
  logic     rd_req;
  addr_t    rd_addr;
  logic     rd_valid;
  word_t    rd_data;
  logic     wr_req;
  addr_t    wr_addr;
  word_t    wr_data;
  logic     wr_ready;

  word_t shadow [addr_t];     // CPU view of memory
  word_t mem_words [addr_t];  // Words that came back from write bursts
  logic  dirty_lines [addr_t]; // Lines stored to since their last write burst
  int    rd_bursts;
  int    wr_bursts;
  int    bus_errors;
  int    check_errors;
  int    timeouts;
  int    other_errors;
  int    requests;
  logic  timed_out;
  int    max_wait = 2000;

  dcache_top i_dcache_top (
    .clk(clk), .rst(rst), .req(req), .we(we), .addr(addr), .wdata(wdata),
    .byte_en(byte_en), .rdata(rdata), .ok(ok), .rd_req(rd_req), .rd_addr(rd_addr),
    .rd_valid(rd_valid), .rd_data(rd_data), .wr_req(wr_req), .wr_addr(wr_addr),
    .wr_data(wr_data), .wr_ready(wr_ready));

  bind dcache_top dcache_properties i_dcache_properties (
    .clk(clk), .rst(rst), .ok(ok), .rd_req(rd_req), .wr_req(wr_req),
    .rd_addr(rd_addr), .wr_addr(wr_addr));

  function automatic word_t fill_pattern(addr_t a);
    return a ^ 32'h5a5a0000;
  endfunction

  function automatic word_t expected_word(addr_t a);
    if (shadow.exists(a))
      return shadow[a];
    return fill_pattern(a);
  endfunction

  function automatic word_t memory_word(addr_t a);
    if (mem_words.exists(a))
      return mem_words[a];
    return fill_pattern(a);
  endfunction

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h80200003; // Taps 32, 22, 2, 1
    return s >> 1;
  endfunction

  function automatic word_t merge_bytes(word_t old, word_t data, byte_en_t be);
    word_t w;
    w = old;
    for (int b = 0; b < 4; b++)
      if (be[b])
        w[8*b +: 8] = data[8*b +: 8];
    return w;
  endfunction

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Memory model with random stalls

  initial
  begin : memory_model
    logic [31:0] lfsr;
    logic        rd_busy;
    logic        wr_busy;
    int          rd_beat;
    int          wr_beat;
    addr_t       a;
    lfsr       = 32'h710f4109;
    rd_busy    = 1'b0;
    wr_busy    = 1'b0;
    rd_beat    = 0;
    wr_beat    = 0;
    rd_bursts  = 0;
    wr_bursts  = 0;
    bus_errors = 0;
    rd_valid <= 1'b0;
    rd_data  <= '0;
    wr_ready <= 1'b0;
    forever
    begin
      @(posedge clk);
      if (rd_req)
      begin
        if (!rd_busy)
        begin
          rd_busy = 1'b1;
          rd_beat = 0;
          rd_bursts++;
          if (rd_addr !== {addr[31:6], 6'b0}) // Line of the pending request
          begin
            $display("Mismatch at %0t: rd_addr got %h expected %h", $time, rd_addr,
                     {addr[31:6], 6'b0});
            bus_errors++;
          end
        end
        else if (rd_valid)
          rd_beat++;
        lfsr = lfsr_next(lfsr);
        rd_valid <= lfsr[0];
        rd_data  <= memory_word(rd_addr + addr_t'(rd_beat * 4));
      end
      else
      begin
        if (rd_busy && rd_beat != 16)
        begin
          $display("Mismatch at %0t: read burst length got %0d expected 16", $time, rd_beat);
          bus_errors++;
        end
        rd_busy = 1'b0;
        rd_valid <= 1'b0;
      end

      if (wr_req)
      begin
        if (!wr_busy)
        begin
          wr_busy = 1'b1;
          wr_beat = 0;
          wr_bursts++;
          if (!dirty_lines.exists(wr_addr))
          begin
            $display("Error at %0t: write burst to line %h that holds no stored data",
                     $time, wr_addr);
            bus_errors++;
          end
          else
            dirty_lines.delete(wr_addr);
        end
        else if (wr_ready)
        begin
          a = wr_addr + addr_t'(wr_beat * 4);
          if (wr_data !== expected_word(a))
          begin
            $display("Mismatch at %0t: wr_data at %h got %h expected %h", $time, a, wr_data,
                     expected_word(a));
            bus_errors++;
          end
          mem_words[a] = wr_data;
          wr_beat++;
        end
        lfsr = lfsr_next(lfsr);
        wr_ready <= lfsr[0];
      end
      else
      begin
        if (wr_busy && wr_beat != 16)
        begin
          $display("Mismatch at %0t: write burst length got %0d expected 16", $time, wr_beat);
          bus_errors++;
        end
        wr_busy = 1'b0;
        wr_ready <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // CPU side

  task automatic expect_low(input string name, input logic value);
    if (value !== 1'b0)
    begin
      $display("Mismatch at %0t: %s got %b expected 0", $time, name, value);
      check_errors++;
    end
  endtask

  task automatic run_request(input logic is_write, input addr_t a, input word_t d,
                             input byte_en_t be, input word_t exp_rdata,
                             input logic exp_refill);
    int    waited;
    int    bursts_before;
    logic  got;
    logic  refilled;
    word_t got_rdata;
    bursts_before = rd_bursts;
    got       = 1'b0;
    got_rdata = '0;
    waited    = 0;
    @(posedge clk);
    req     <= 1'b1;
    we      <= is_write;
    addr    <= a;
    wdata   <= d;
    byte_en <= be;
    while (!got && waited < max_wait)
    begin
      @(negedge clk);
      if (ok)
      begin
        got       = 1'b1;
        got_rdata = rdata;
      end
      waited++;
    end
    @(posedge clk);
    req <= 1'b0;
    if (!got)
    begin
      $display("Error at %0t: no ok within %0d cycles for address %h", $time, max_wait, a);
      timeouts++;
      timed_out = 1'b1;
    end
    else
    begin
      refilled = rd_bursts != bursts_before;
      if (!is_write && got_rdata !== exp_rdata)
      begin
        $display("Mismatch at %0t: rdata for %h got %h expected %h", $time, a, got_rdata,
                 exp_rdata);
        check_errors++;
      end
      if (refilled !== exp_refill)
      begin
        $display("Mismatch at %0t: refill for %h got %b expected %b", $time, a, refilled,
                 exp_refill);
        check_errors++;
      end
      if (is_write)
      begin
        shadow[{a[31:2], 2'b00}] = merge_bytes(expected_word({a[31:2], 2'b00}), d, be);
        dirty_lines[{a[31:6], 6'b0}] = 1'b1;
      end
    end
  endtask

  initial
  begin : stimulus
    int               fd;
    int               n;
    logic [8*128-1:0] text;
    logic             is_write;
    addr_t            a;
    word_t            d;
    byte_en_t         be;
    word_t            exp_rdata;
    logic             exp_refill;
    req     <= 1'b0;
    we      <= 1'b0;
    addr    <= '0;
    wdata   <= '0;
    byte_en <= '0;
    rst     <= 1'b1;
    check_errors = 0;
    timeouts     = 0;
    other_errors = 0;
    requests     = 0;
    timed_out    = 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // Quiet outputs before the first request
    repeat (4)
    begin
      @(negedge clk);
      expect_low("ok", ok);
      expect_low("rd_req", rd_req);
      expect_low("wr_req", wr_req);
    end

    fd = $fopen("verification/dcache_golden.txt", "r");
    if (fd == 0)
    begin
      $display("Error: cannot open verification/dcache_golden.txt");
      other_errors++;
    end
    else
    begin
      n = $fgets(text, fd); // Two column header lines
      n = $fgets(text, fd);
      while (!timed_out)
      begin
        n = $fscanf(fd, "%h %h %h %h %h %h", is_write, a, d, be, exp_rdata, exp_refill);
        if (n != 6)
          break;
        run_request(is_write, a, d, be, exp_rdata, exp_refill);
        requests++;
      end
      $fclose(fd);
      if (requests == 0)
      begin
        $display("Error: no requests found in the golden file");
        other_errors++;
      end
    end

    if (wr_bursts != 1) // Only the stored line in set 1 is ever evicted
    begin
      $display("Mismatch at %0t: wr_bursts got %0d expected 1", $time, wr_bursts);
      check_errors++;
    end

    $display("Errors: %0d check, %0d bus, %0d timeout, %0d other", check_errors, bus_errors,
             timeouts, other_errors);
    if (check_errors + bus_errors + timeouts + other_errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* verification/dcache_golden.txt */
// op(0 read, 1 write) addr wdata byte_en rdata refill, all hex
// rdata is ignored on writes, refill is 1 when the request must raise rd_req
0 00001048 00000000 0 5a5a1048 1
0 0000107c 00000000 0 5a5a107c 0
1 00001050 aabbccdd 5 00000000 0
0 00001050 00000000 0 5abb10dd 0
0 00001440 00000000 0 5a5a1440 1
0 00001840 00000000 0 5a5a1840 1
0 00001c40 00000000 0 5a5a1c40 1
0 00002040 00000000 0 5a5a2040 1
0 00001050 00000000 0 5abb10dd 1
0 00003080 00000000 0 5a5a3080 1
0 00003484 00000000 0 5a5a3484 1
0 00003888 00000000 0 5a5a3888 1
0 00003c8c 00000000 0 5a5a3c8c 1
0 00003090 00000000 0 5a5a3090 0
0 00004080 00000000 0 5a5a4080 1
0 000030bc 00000000 0 5a5a30bc 0
0 000034a0 00000000 0 5a5a34a0 1
0 00003880 00000000 0 5a5a3880 1
1 000050c4 12345678 f 00000000 1
0 000050c4 00000000 0 12345678 0
1 000050c8 cafef00d a 00000000 0
0 000050c8 00000000 0 ca5af0c8 0
0 00001048 00000000 0 5a5a1048 0

/* verilog.f */
logic/dcache_geom_pkg.sv
logic/dcache_bus_pkg.sv
logic/set_ram.sv
logic/lru_tracker.sv
logic/way_lookup.sv
logic/line_mover.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
verification/dcache_properties.sv
verification/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module dcache_tb -f verilog.f -o dcache_sim
./obj_dir/dcache_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "Run failed, see sim.log"
  exit 1
fi
echo "Run finished, see sim.log"
